//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       = ifu_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
PASS_MSG  = STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Output is shown and searched for the pass line, without a log file.
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
+incdir+logic
logic/rv_isa_pkg.sv
logic/ifu_pkg.sv
logic/pc_gen.sv
logic/inst_rom.sv
logic/ifu_machine.sv
logic/inst_predecode.sv
logic/ifu_top.sv
tests/ifu_tb.sv

//--- logic/ifu_machine.sv
/*
 * Fetch hand-off state machine.
 * Captures pc and instruction on the memory valid pulse and holds
 * them with a valid level until the next stage is ready.
 */

`timescale 1ns/1ns

`include "ifu_macros.svh"

module ifu_machine (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  mem_valid,
    input  ifu_pkg::pc_t          mem_pc,
    input  logic [31:0]           mem_inst,
    input  logic                  wbu_ready,
    output logic                  ifu_valid,
    output logic                  accept,
    output ifu_pkg::pc_t          pc,
    output rv_isa_pkg::rv_inst_t  inst
);

    import ifu_pkg::*;

    fetch_state_t state;
    fetch_state_t next_state;
    logic         capture;

    assign capture = (state == FS_IDLE) & mem_valid;  // Only load point.

    always_comb begin
        next_state = state;
        case (state)
            FS_IDLE:       if (mem_valid) next_state = FS_WAIT_READY;
            FS_WAIT_READY: if (wbu_ready) next_state = FS_IDLE;
            default:       next_state = FS_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) state <= FS_IDLE;
        else     state <= next_state;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc   <= `IFU_PC_RST;
            inst <= '0;
        end else if (capture) begin
            pc   <= mem_pc;
            inst <= mem_inst;
        end
    end

    assign ifu_valid = (state == FS_WAIT_READY);
    assign accept    = ifu_valid & wbu_ready;  // Transfer edge, restarts fetch.

    // Memory answers only a request issued after the last transfer.
    a_valid_in_idle: assert property (@(posedge clk) disable iff (rst)
        mem_valid |-> state == FS_IDLE);

    // Stalled output stays put and keeps its valid.
    a_hold_stall: assert property (@(posedge clk) disable iff (rst)
        (ifu_valid && !wbu_ready) |=> (ifu_valid && $stable(pc) && $stable(inst)));

endmodule

//--- logic/ifu_macros.svh
/*
 * Fetch unit sizing macros.
 * Reset fetch address, ROM word-address width and ROM depth.
 */

`ifndef IFU_MACROS_SVH
`define IFU_MACROS_SVH

// First fetch address after reset.
`define IFU_PC_RST      32'h8000_0000

// ROM word-address bits, 256 words.
`define IFU_ROM_AW      8

// Depth follows the address width.
`define IFU_ROM_DEPTH   (1 << `IFU_ROM_AW)

`endif

//--- logic/ifu_pkg.sv
/*
 * Fetch unit types.
 * Address word and the fetch handshake state.
 */

package ifu_pkg;

    // Byte address, always word aligned in fetch.
    typedef logic [31:0] pc_t;

    // Idle until memory returns a word, then hold it until taken.
    typedef enum logic {
        FS_IDLE       = 1'b0,
        FS_WAIT_READY = 1'b1
    } fetch_state_t;

endpackage

//--- logic/ifu_top.sv
/*
 * Instruction fetch unit top.
 * PC generator, instruction ROM, hand-off FSM and predecode,
 * with the ROM load port and the downstream valid/ready link.
 */

`timescale 1ns/1ns

`include "ifu_macros.svh"

module ifu_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     load_en,
    input  logic [`IFU_ROM_AW-1:0]   load_addr,
    input  logic [31:0]              load_data,
    input  logic                     wbu_ready,
    output logic                     ifu_valid,
    output ifu_pkg::pc_t             pc,
    output rv_isa_pkg::rv_inst_t     inst,
    output rv_isa_pkg::inst_class_t  inst_class,
    output logic [31:0]              imm
);

    import ifu_pkg::*;

    logic        fetch_req;     // Request pulse to memory.
    pc_t         fetch_pc;
    logic        mem_valid;     // Word returned.
    logic [31:0] mem_inst;
    pc_t         mem_pc;
    logic        accept;        // Downstream transfer.
    logic        redirect;      // JAL held.
    pc_t         redirect_pc;

    pc_gen pc_gen_inst (
        .clk         (clk),
        .rst         (rst),
        .accept      (accept),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fetch_req   (fetch_req),
        .fetch_pc    (fetch_pc)
    );

    inst_rom inst_rom_inst (
        .clk       (clk),
        .rst       (rst),
        .fetch_req (fetch_req),
        .fetch_pc  (fetch_pc),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .mem_valid (mem_valid),
        .mem_inst  (mem_inst),
        .mem_pc    (mem_pc)
    );

    ifu_machine ifu_machine_inst (
        .clk       (clk),
        .rst       (rst),
        .mem_valid (mem_valid),
        .mem_pc    (mem_pc),
        .mem_inst  (mem_inst),
        .wbu_ready (wbu_ready),
        .ifu_valid (ifu_valid),
        .accept    (accept),
        .pc        (pc),
        .inst      (inst)
    );

    inst_predecode inst_predecode_inst (
        .pc          (pc),
        .inst        (inst),
        .inst_class  (inst_class),
        .imm         (imm),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

endmodule

//--- logic/inst_predecode.sv
/*
 * Instruction predecode.
 * Format class and sign-extended immediate of the held word,
 * plus the static JAL redirect back to the PC generator.
 */

`timescale 1ns/1ns

module inst_predecode (
    input  ifu_pkg::pc_t             pc,
    input  rv_isa_pkg::rv_inst_t     inst,
    output rv_isa_pkg::inst_class_t  inst_class,
    output logic [31:0]              imm,
    output logic                     redirect,
    output ifu_pkg::pc_t             redirect_pc
);

    import rv_isa_pkg::*;

    logic [6:0]  opcode;
    logic [31:0] imm_j;

    assign opcode = inst.r_fmt.opcode;   // Same bits in every format.

    assign imm_j = {{11{inst.j_fmt.imm_20}}, inst.j_fmt.imm_20, inst.j_fmt.imm_19_12,
                    inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};

    always_comb begin
        case (opcode)
            OPC_OP:                         inst_class = CLS_R;
            OPC_OP_IMM, OPC_LOAD, OPC_JALR: inst_class = CLS_I;
            OPC_STORE:                      inst_class = CLS_S;
            OPC_BRANCH:                     inst_class = CLS_B;
            OPC_LUI, OPC_AUIPC:             inst_class = CLS_U;
            OPC_JAL:                        inst_class = CLS_J;
            default:                        inst_class = CLS_BAD;
        endcase
    end

    always_comb begin
        case (inst_class)
            CLS_I: imm = {{20{inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
            CLS_S: imm = {{20{inst.s_fmt.imm_11_5[6]}}, inst.s_fmt.imm_11_5,
                          inst.s_fmt.imm_4_0};
            CLS_B: imm = {{19{inst.b_fmt.imm_12}}, inst.b_fmt.imm_12, inst.b_fmt.imm_11,
                          inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
            CLS_U: imm = {inst.u_fmt.imm_31_12, 12'b0};  // Upper field only.
            CLS_J: imm = imm_j;
            default: imm = 32'b0;                         // R and BAD carry none.
        endcase
    end

    // Only JAL has a target known at fetch.
    assign redirect    = (opcode == OPC_JAL);
    assign redirect_pc = pc + imm_j;

endmodule

//--- logic/inst_rom.sv
/*
 * On-chip instruction memory.
 * Word array with a load port, registered read and a valid pulse
 * one cycle after each request, returned with the request address.
 */

`timescale 1ns/1ns

`include "ifu_macros.svh"

module inst_rom (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fetch_req,
    input  ifu_pkg::pc_t           fetch_pc,
    input  logic                   load_en,
    input  logic [`IFU_ROM_AW-1:0] load_addr,
    input  logic [31:0]            load_data,
    output logic                   mem_valid,
    output logic [31:0]            mem_inst,
    output ifu_pkg::pc_t           mem_pc
);

    logic [31:0]            mem [`IFU_ROM_DEPTH];
    logic [`IFU_ROM_AW-1:0] rd_addr;

    assign rd_addr = fetch_pc[`IFU_ROM_AW+1:2];   // Word index, wraps mod depth.

    // Image written through the load port.
    always_ff @(posedge clk) begin
        if (load_en) mem[load_addr] <= load_data;
    end

    // Word and its address, both registered with the request.
    always_ff @(posedge clk) begin
        if (fetch_req) begin
            mem_inst <= mem[rd_addr];
            mem_pc   <= fetch_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) mem_valid <= 1'b0;
        else     mem_valid <= fetch_req;   // Exactly one cycle later.
    end

    // One fetch in flight, so requests are never back to back.
    a_no_b2b_req: assert property (@(posedge clk) disable iff (rst)
        fetch_req |=> !fetch_req);

endmodule

//--- logic/pc_gen.sv
/*
 * Program counter generator.
 * Holds the fetch address, picks sequential or redirect target
 * on acceptance and issues one fetch request pulse per fetch.
 */

`timescale 1ns/1ns

`include "ifu_macros.svh"

module pc_gen (
    input  logic             clk,
    input  logic             rst,
    input  logic             accept,
    input  logic             redirect,
    input  ifu_pkg::pc_t     redirect_pc,
    output logic             fetch_req,
    output ifu_pkg::pc_t     fetch_pc
);

    import ifu_pkg::*;

    logic boot;     // Set by reset, starts the very first fetch.
    pc_t  seq_pc;   // Fall-through address.

    assign seq_pc = fetch_pc + 32'd4;

    always_ff @(posedge clk) begin
        if (rst) begin
            boot      <= 1'b1;
            fetch_req <= 1'b0;
        end else begin
            boot      <= 1'b0;
            fetch_req <= boot | accept;    // Single pulse per start.
        end
    end

    // Next address only moves on a downstream transfer.
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_pc <= `IFU_PC_RST;
        end else if (accept) begin
            fetch_pc <= redirect ? redirect_pc : seq_pc;  // JAL wins.
        end
    end

    // Redirect targets must keep the fetch stream on word boundaries.
    a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
        fetch_pc[1:0] == 2'b00);

endmodule

//--- logic/rv_isa_pkg.sv
/*
 * RV32I encoding definitions.
 * Per-format instruction structs and their union, base opcodes,
 * and the format class enum used by predecode.
 */

package rv_isa_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One word, six views. Opcode sits in bits 6:0 for all of them.
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } rv_inst_t;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    typedef enum logic [2:0] {
        CLS_R,
        CLS_I,
        CLS_S,
        CLS_B,
        CLS_U,
        CLS_J,
        CLS_BAD     // Opcode outside the supported set.
    } inst_class_t;

endpackage

//--- tests/ifu_tb.sv
/*
 * Fetch unit testbench.
 * Random ROM image loaded under reset, random downstream ready,
 * reference pc and decode model, typed compare tasks.
 */

`timescale 1ns/1ns

`include "ifu_macros.svh"

module ifu_tb;

    import ifu_pkg::*;
    import rv_isa_pkg::*;

    localparam int N_XFER  = 300;   // Transfers before the run ends.
    localparam int TIMEOUT = 50;    // Cycles allowed per wait.

    logic                   clk;
    logic                   rst;
    logic                   load_en;
    logic [`IFU_ROM_AW-1:0] load_addr;
    logic [31:0]            load_data;
    logic                   wbu_ready;
    logic                   ifu_valid;
    pc_t                    pc;
    rv_inst_t               inst;
    inst_class_t            inst_class;
    logic [31:0]            imm;

    integer      seed;
    logic [31:0] rom_model [`IFU_ROM_DEPTH];   // Copy of the loaded image.
    pc_t         model_pc;                     // Next pc expected downstream.
    int          n_check [1:4];                // Per behavior.
    int          n_err   [1:4];
    int          n_xfer;
    bit          timed_out;

    ifu_top ifu_top_inst (
        .clk        (clk),
        .rst        (rst),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .wbu_ready  (wbu_ready),
        .ifu_valid  (ifu_valid),
        .pc         (pc),
        .inst       (inst),
        .inst_class (inst_class),
        .imm        (imm)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reference decode, straight from the RV32I bit layout.
    function automatic inst_class_t model_class(input logic [31:0] w);
        case (w[6:0])
            OPC_OP:                         return CLS_R;
            OPC_OP_IMM, OPC_LOAD, OPC_JALR: return CLS_I;
            OPC_STORE:                      return CLS_S;
            OPC_BRANCH:                     return CLS_B;
            OPC_LUI, OPC_AUIPC:             return CLS_U;
            OPC_JAL:                        return CLS_J;
            default:                        return CLS_BAD;
        endcase
    endfunction

    function automatic logic [31:0] model_imm(input logic [31:0] w);
        case (w[6:0])
            OPC_OP_IMM, OPC_LOAD, OPC_JALR: return {{20{w[31]}}, w[31:20]};
            OPC_STORE:  return {{20{w[31]}}, w[31:25], w[11:7]};
            OPC_BRANCH: return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            OPC_LUI, OPC_AUIPC: return {w[31:12], 12'b0};
            OPC_JAL:    return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default:    return 32'b0;   // R and invalid.
        endcase
    endfunction

    // Quarter JAL, the rest spread over valid and invalid opcodes.
    function automatic logic [31:0] random_word();
        logic [31:0] w;
        int          sel;
        w   = $random(seed);
        sel = {$random(seed)} % 16;
        case (sel)
            0, 1, 2, 3: begin
                w[6:0] = OPC_JAL;
                w[21]  = 1'b0;       // Imm bit 1 clear, target stays word aligned.
            end
            4:  w[6:0] = OPC_LUI;
            5:  w[6:0] = OPC_AUIPC;
            6:  w[6:0] = OPC_JALR;
            7:  w[6:0] = OPC_BRANCH;
            8:  w[6:0] = OPC_LOAD;
            9:  w[6:0] = OPC_STORE;
            10: w[6:0] = OPC_OP_IMM;
            11: w[6:0] = OPC_OP;
            12: w[6:0] = OPC_OP_IMM;
            13: w[6:0] = 7'b0001111; // Fence, not decoded here.
            14: w[6:0] = 7'b1110011; // System.
            default: w[6:0] = 7'b0000000;
        endcase
        return w;
    endfunction

    task automatic check_pc(input int beh, input string name, input pc_t got, input pc_t exp);
        n_check[beh]++;
        if (got !== exp) begin
            n_err[beh]++;
            $display("mismatch %s: got %h expected %h (transfer %0d)", name, got, exp, n_xfer);
        end
    endtask

    task automatic check_inst(input int beh, input string name,
                              input rv_inst_t got, input rv_inst_t exp);
        n_check[beh]++;
        if (got !== exp) begin
            n_err[beh]++;
            $display("mismatch %s: got %h expected %h (transfer %0d)", name, got, exp, n_xfer);
        end
    endtask

    task automatic check_class(input int beh, input string name,
                               input inst_class_t got, input inst_class_t exp);
        n_check[beh]++;
        if (got !== exp) begin
            n_err[beh]++;
            $display("mismatch %s: got %h expected %h (transfer %0d)", name, got, exp, n_xfer);
        end
    endtask

    task automatic check_imm(input int beh, input string name,
                             input logic [31:0] got, input logic [31:0] exp);
        n_check[beh]++;
        if (got !== exp) begin
            n_err[beh]++;
            $display("mismatch %s: got %h expected %h (transfer %0d)", name, got, exp, n_xfer);
        end
    endtask

    // Drive ready on the rising edge, come back at the falling edge to sample.
    task automatic next_cycle();
        @(posedge clk);
        wbu_ready <= (32'($random(seed)) & 32'd3) != 32'd0;   // High about 3 in 4.
        @(negedge clk);
    endtask

    task automatic fill_rom();
        logic [31:0] w;
        for (int i = 0; i < `IFU_ROM_DEPTH; i++) begin
            w            = random_word();
            rom_model[i] = w;
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= i[`IFU_ROM_AW-1:0];
            load_data <= w;
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic wait_valid(output bit ok);
        int cycles;
        cycles = 0;
        ok     = ifu_valid;
        while (!ok && cycles < TIMEOUT) begin
            next_cycle();
            cycles++;
            ok = ifu_valid;
        end
    endtask

    task automatic report_behavior(input int beh, input string what);
        $display("behavior %0d %s: %0d checks, %0d errors", beh, what,
                 n_check[beh], n_err[beh]);
    endtask

    // One held word, checked, stalled as ready says, then taken.
    task automatic transfer_one();
        logic [31:0] exp_word;
        pc_t         held_pc;
        rv_inst_t    held_inst;
        int          stall;
        exp_word = rom_model[model_pc[`IFU_ROM_AW+1:2]];   // Wraps mod ROM size.
        if (n_xfer == 0) begin
            check_pc(1, "pc", pc, `IFU_PC_RST);
            check_inst(1, "inst", inst, rom_model[0]);
        end
        check_pc(2, "pc", pc, model_pc);
        check_inst(2, "inst", inst, exp_word);
        check_class(3, "inst_class", inst_class, model_class(exp_word));
        check_imm(3, "imm", imm, model_imm(exp_word));
        held_pc   = pc;
        held_inst = inst;
        stall     = 0;
        while (!wbu_ready && stall < TIMEOUT) begin
            next_cycle();
            stall++;
            if (!ifu_valid) begin
                n_err[4]++;
                $display("ifu_valid dropped while stalled at pc %h", held_pc);
            end
            check_pc(4, "pc", pc, held_pc);
            check_inst(4, "inst", inst, held_inst);
        end
        if (!wbu_ready) begin
            timed_out = 1'b1;
            $display("timeout: wbu_ready stayed low for %0d cycles", TIMEOUT);
        end else begin
            // Transfer on the coming edge. JAL jumps, everything else falls through.
            if (exp_word[6:0] == OPC_JAL) model_pc = model_pc + model_imm(exp_word);
            else                          model_pc = model_pc + 32'd4;
            n_xfer++;
            if (n_xfer == 1) report_behavior(1, "first fetch after reset");
            next_cycle();
        end
    endtask

    initial begin
        bit ok;
        int total_chk;
        int total_err;
        rst       = 1'b1;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        wbu_ready = 1'b0;
        seed      = 12344;
        model_pc  = `IFU_PC_RST;
        n_xfer    = 0;
        timed_out = 1'b0;
        foreach (n_check[b]) begin
            n_check[b] = 0;
            n_err[b]   = 0;
        end
        fill_rom();                  // Image goes in while reset is high.
        repeat (2) @(posedge clk);   // Reset cycles with the load port idle.
        rst <= 1'b0;
        @(negedge clk);
        while (n_xfer < N_XFER && !timed_out) begin
            wait_valid(ok);
            if (!ok) begin
                timed_out = 1'b1;
                $display("timeout: ifu_valid not seen within %0d cycles", TIMEOUT);
            end else begin
                transfer_one();
            end
        end
        report_behavior(2, "pc sequence and fetched words");
        report_behavior(3, "format class and immediate");
        report_behavior(4, "hold under back-pressure");
        total_chk = n_check[1] + n_check[2] + n_check[3] + n_check[4];
        total_err = n_err[1] + n_err[2] + n_err[3] + n_err[4];
        $display("summary: %0d transfers, %0d checks, %0d errors, timeout %0d",
                 n_xfer, total_chk, total_err, timed_out);
        if (total_err == 0 && !timed_out) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
